//--- l2_cache.f
hw/l2_cache_pkg.sv
hw/cache_ctrl_if.sv
hw/l2_cache_datapath.sv
hw/ewb.sv
hw/l2_cache_control.sv
hw/l2_cache.sv
tests/pmem_model.sv
tests/l2_cache_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert --top-module l2_cache_tb -f l2_cache.f \
    && ./obj_dir/Vl2_cache_tb; } > sim.log 2>&1 || echo "test failed" >> sim.log
cat sim.log
grep -q "test failed" sim.log && exit 1 || exit 0

//--- tests/l2_cache_tb.sv
module l2_cache_tb;

    localparam int clk_period  = 100;
    localparam int drive_delay = 10;
    localparam int max_cycles  = 200 * 40;
    localparam int line_bits   = l2_cache_pkg::line_width;

    logic                 clk;
    logic                 arst_n;
    logic [31:0]          mem_address;
    logic [line_bits-1:0] mem_rdata;
    logic [line_bits-1:0] mem_wdata;
    logic                 mem_read;
    logic                 mem_write;
    logic                 mem_resp;
    logic [31:0]          pmem_address;
    logic [line_bits-1:0] pmem_rdata;
    logic [line_bits-1:0] pmem_wdata;
    logic                 pmem_read;
    logic                 pmem_write;
    logic                 pmem_resp;

    logic [line_bits-1:0] ref_q [logic [26:0]]; // expected lines, written ones only.
    int                   cycle_count = 0;
    int                   seed;

    l2_cache dut (
        .clk(clk), .arst_n_i(arst_n),
        .mem_address_i(mem_address), .mem_rdata_o(mem_rdata), .mem_wdata_i(mem_wdata),
        .mem_read_i(mem_read), .mem_write_i(mem_write), .mem_resp_o(mem_resp),
        .pmem_address_o(pmem_address), .pmem_rdata_i(pmem_rdata), .pmem_wdata_o(pmem_wdata),
        .pmem_read_o(pmem_read), .pmem_write_o(pmem_write), .pmem_resp_i(pmem_resp)
    );

    pmem_model pmem (
        .clk(clk), .arst_n_i(arst_n), .address_i(pmem_address), .wdata_i(pmem_wdata),
        .read_i(pmem_read), .write_i(pmem_write), .rdata_o(pmem_rdata), .resp_o(pmem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) stop_run("timeout, the cache stopped answering requests");
    end

    function automatic logic [line_bits-1:0] memory_pattern(input logic [26:0] line);
        logic [31:0] word;
        word = {line, 5'b0} ^ 32'h5a5a_0000;
        return {8{word}};
    endfunction

    function automatic logic [31:0] line_addr(input logic [23:0] tag, input logic [2:0] set);
        return {tag, set, 5'b0};
    endfunction

    function automatic logic [line_bits-1:0] random_line();
        logic [line_bits-1:0] value;
        for (int i = 0; i < 8; i++) value[i*32 +: 32] = $random(seed);
        return value;
    endfunction

    // one upstream request. latency counts rising edges until mem_resp_o.
    task automatic issue_request(input logic is_write, input logic [31:0] addr,
                                 input logic [line_bits-1:0] wdata,
                                 output int cycles, output logic fetched);
        logic [26:0]          line;
        logic [line_bits-1:0] expected;
        line        = addr[31:5];
        expected    = ref_q.exists(line) ? ref_q[line] : memory_pattern(line);
        cycles      = 0;
        fetched     = 1'b0;
        mem_address = addr;
        mem_wdata   = wdata;
        mem_read    = !is_write;
        mem_write   = is_write;
        @(negedge clk);
        while (!mem_resp) begin
            fetched = fetched | pmem_read;
            cycles++;
            @(negedge clk);
        end
        if (is_write) ref_q[line] = wdata;
        else assert (mem_rdata === expected) else stop_run($sformatf(
            "MISMATCH at %0t: mem_rdata_o is %h, expected %h", $time, mem_rdata, expected));
        @(posedge clk);
        #drive_delay;
        mem_read  = 1'b0;
        mem_write = 1'b0;
    endtask

    task automatic check_written_back(input logic [26:0] line);
        assert (pmem.logged(line)) else stop_run($sformatf("line %h never reached memory", line));
        assert (pmem.logged_line(line) === ref_q[line]) else stop_run($sformatf(
            "MISMATCH at %0t: pmem_wdata_o for line %h is %h, expected %h",
            $time, line, pmem.logged_line(line), ref_q[line]));
    endtask

    task automatic check_read_miss();
        int   cycles;
        logic fetched;
        issue_request(1'b0, line_addr(24'h00_0010, 3'd1), '0, cycles, fetched);
        assert (fetched) else stop_run("read miss did not fetch the line from memory");
        issue_request(1'b0, line_addr(24'h00_0010, 3'd1), '0, cycles, fetched);
        assert (!fetched) else stop_run("second read of a cached line went to memory");
    endtask

    task automatic check_write_hit();
        int   cycles;
        logic fetched;
        issue_request(1'b1, line_addr(24'h00_0020, 3'd2), random_line(), cycles, fetched);
        issue_request(1'b0, line_addr(24'h00_0020, 3'd2), '0, cycles, fetched);
        assert (cycles == 2) else stop_run($sformatf(
            "MISMATCH at %0t: mem_resp_o latency is %0d, expected 2", $time, cycles));
        assert (!fetched) else stop_run("read hit raised pmem_read_o");
    endtask

    // five lines into set 3. the plru victim is the first one.
    task automatic check_eviction();
        int          cycles;
        logic        fetched;
        logic [31:0] first;
        first = line_addr(24'h00_0100, 3'd3);
        for (int i = 0; i < 5; i++) begin
            issue_request(1'b1, line_addr(24'(32'h100 + i), 3'd3), random_line(), cycles, fetched);
        end
        issue_request(1'b0, first, '0, cycles, fetched); // still in the eviction buffer.
        assert (cycles == 2 && !fetched) else stop_run("buffered line was not served directly");
        repeat (20) @(posedge clk);
        #drive_delay;
        check_written_back(first[31:5]);
    endtask

    task automatic check_random();
        int          cycles;
        logic        fetched;
        int          r;
        logic [2:0]  set;
        for (int n = 0; n < 150; n++) begin
            r   = $random(seed);
            set = 3'(4 + ($unsigned(r) >> 3) % 3);
            issue_request(r[31], {24'h00_0200 | {21'b0, r[2:0]}, set, r[28:24]},
                          random_line(), cycles, fetched);
        end
        // four unused lines per set push every dirty line out.
        for (int s = 0; s < 8; s++) begin
            for (int k = 0; k < 4; k++) begin
                issue_request(1'b0, line_addr(24'(32'hf000 + k), 3'(s)), '0, cycles, fetched);
            end
        end
        repeat (20) @(posedge clk);
        #drive_delay;
        foreach (ref_q[line]) check_written_back(line);
    endtask

    initial begin
        arst_n      = 1'b0;
        mem_address = '0;
        mem_wdata   = '0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        seed        = 32'hfd60_91d3;
        repeat (3) @(posedge clk);
        #drive_delay;
        arst_n = 1'b1;
        assert (!mem_resp && !pmem_read && !pmem_write)
            else stop_run("handshake outputs are high after reset");
        check_read_miss();
        check_write_hit();
        check_eviction();
        check_random();
        $display("test passed");
        $finish;
    end

endmodule

//--- tests/pmem_model.sv
module pmem_model #(
    parameter int latency = 4
) (
    input  logic                                clk,
    input  logic                                arst_n_i,
    input  logic [31:0]                         address_i,
    input  logic [l2_cache_pkg::line_width-1:0] wdata_i,
    input  logic                                read_i,
    input  logic                                write_i,
    output logic [l2_cache_pkg::line_width-1:0] rdata_o,
    output logic                                resp_o
);

    logic [l2_cache_pkg::line_width-1:0] log_q [logic [26:0]]; // last write per line.
    int                                  wait_q;

    // contents of a line that memory never saw written.
    function automatic logic [l2_cache_pkg::line_width-1:0] fill_line(input logic [26:0] line);
        return {8{{line, 5'b0} ^ 32'h5a5a_0000}};
    endfunction

    function automatic bit logged(input logic [26:0] line);
        return log_q.exists(line) != 0;
    endfunction

    function automatic logic [l2_cache_pkg::line_width-1:0] logged_line(input logic [26:0] line);
        return log_q[line];
    endfunction

    // answers latency cycles after the request shows up.
    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            resp_o  <= 1'b0;
            rdata_o <= '0;
            wait_q  <= 0;
        end else begin
            resp_o <= 1'b0;
            if ((read_i || write_i) && !resp_o) begin
                if (wait_q == latency - 1) begin
                    wait_q <= 0;
                    resp_o <= 1'b1;
                    if (write_i) begin
                        log_q[address_i[31:5]] = wdata_i;
                    end else if (log_q.exists(address_i[31:5]) != 0) begin
                        rdata_o <= log_q[address_i[31:5]];
                    end else begin
                        rdata_o <= fill_line(address_i[31:5]);
                    end
                end else begin
                    wait_q <= wait_q + 1;
                end
            end
        end
    end

endmodule

//--- hw/l2_cache.sv
module l2_cache (
    input  logic                                clk,
    input  logic                                arst_n_i,

    input  logic [31:0]                         mem_address_i,
    output logic [l2_cache_pkg::line_width-1:0] mem_rdata_o,
    input  logic [l2_cache_pkg::line_width-1:0] mem_wdata_i,
    input  logic                                mem_read_i,
    input  logic                                mem_write_i,
    output logic                                mem_resp_o,

    output logic [31:0]                         pmem_address_o,
    input  logic [l2_cache_pkg::line_width-1:0] pmem_rdata_i,
    output logic [l2_cache_pkg::line_width-1:0] pmem_wdata_o,
    output logic                                pmem_read_o,
    output logic                                pmem_write_o,
    input  logic                                pmem_resp_i
);

    cache_ctrl_if ctrl_bus ();

    logic [l2_cache_pkg::line_width-1:0] dp_rdata;
    logic [l2_cache_pkg::line_width-1:0] ewb_read;
    logic [l2_cache_pkg::line_width-1:0] ewb_wdata;
    logic [31:0]                         dp_address;
    logic [31:0]                         ewb_address;
    logic                                ewb_hit;
    logic                                ewb_empty;
    logic                                ewb_load;
    logic                                ewb_yumi;
    logic                                wb_sel;

    l2_cache_datapath datapath (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .mem_address_i  (mem_address_i),
        .mem_wdata_i    (mem_wdata_i),
        .pmem_rdata_i   (pmem_rdata_i),
        .ctrl           (ctrl_bus.dp),
        .rdata_o        (dp_rdata),
        .pmem_address_o (dp_address)
    );

    // the victim line and its address come straight from the datapath.
    ewb ewb (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .data_i   (dp_rdata),
        .addr_i   (dp_address),
        .load_i   (ewb_load),
        .tag_i    (mem_address_i[31:l2_cache_pkg::s_offset]),
        .hit_o    (ewb_hit),
        .read_o   (ewb_read),
        .empty_o  (ewb_empty),
        .data_o   (ewb_wdata),
        .addr_o   (ewb_address),
        .yumi_i   (ewb_yumi)
    );

    l2_cache_control control (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .mem_read_i   (mem_read_i),
        .mem_write_i  (mem_write_i),
        .mem_resp_o   (mem_resp_o),
        .pmem_read_o  (pmem_read_o),
        .pmem_write_o (pmem_write_o),
        .pmem_resp_i  (pmem_resp_i),
        .ctrl         (ctrl_bus.ctrl),
        .ewb_hit_i    (ewb_hit),
        .ewb_empty_i  (ewb_empty),
        .ewb_load_o   (ewb_load),
        .ewb_yumi_o   (ewb_yumi),
        .wb_sel_o     (wb_sel)
    );

    assign mem_rdata_o = ewb_hit ? ewb_read : dp_rdata; // buffered line wins.

    assign pmem_address_o = wb_sel ? ewb_address : dp_address;
    assign pmem_wdata_o   = wb_sel ? ewb_wdata : dp_rdata;

endmodule

//--- hw/l2_cache_control.sv
module l2_cache_control (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       mem_read_i,
    input  logic       mem_write_i,
    output logic       mem_resp_o,
    output logic       pmem_read_o,
    output logic       pmem_write_o,
    input  logic       pmem_resp_i,
    cache_ctrl_if.ctrl ctrl,
    input  logic       ewb_hit_i,
    input  logic       ewb_empty_i,
    output logic       ewb_load_o,
    output logic       ewb_yumi_o,
    output logic       wb_sel_o
);

    l2_cache_pkg::cache_state_t state_q;
    l2_cache_pkg::cache_state_t state_d;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= l2_cache_pkg::st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d           = state_q;
        mem_resp_o        = 1'b0;
        pmem_read_o       = 1'b0;
        pmem_write_o      = 1'b0;
        ewb_load_o        = 1'b0;
        ewb_yumi_o        = 1'b0;
        wb_sel_o          = 1'b0;
        ctrl.way_load     = '0;
        ctrl.valid_in     = 1'b0;
        ctrl.dirty_in     = 1'b0;
        ctrl.dirty_load   = 1'b0;
        ctrl.lru_load     = 1'b0;
        ctrl.data_sel     = l2_cache_pkg::datamux_wdata;
        ctrl.addr_sel     = l2_cache_pkg::pmemaddr_req;

        case (state_q)
            l2_cache_pkg::st_idle: begin
                // upstream first, buffered write-back only when quiet.
                if (mem_read_i || mem_write_i) begin
                    state_d = l2_cache_pkg::st_lookup;
                end else if (!ewb_empty_i) begin
                    state_d = l2_cache_pkg::st_writeback;
                end
            end

            l2_cache_pkg::st_lookup: begin
                if (ctrl.hit) begin
                    ctrl.lru_load = 1'b1;
                    if (mem_write_i) begin
                        ctrl.way_load[ctrl.hit_way] = 1'b1;
                        ctrl.valid_in   = 1'b1;
                        ctrl.dirty_in   = 1'b1;
                        ctrl.dirty_load = 1'b1;
                    end
                    state_d = l2_cache_pkg::st_respond;
                end else if (mem_read_i && ewb_hit_i) begin
                    state_d = l2_cache_pkg::st_respond; // served from the buffer.
                end else begin
                    // a write to the buffered line also lands here and drains it first.
                    state_d = l2_cache_pkg::st_evict;
                end
            end

            l2_cache_pkg::st_evict: begin
                ctrl.addr_sel = l2_cache_pkg::pmemaddr_victim;
                if (!ewb_empty_i) begin
                    wb_sel_o     = 1'b1;
                    pmem_write_o = 1'b1;
                    ewb_yumi_o   = pmem_resp_i;
                end else begin
                    ewb_load_o = ctrl.victim_dirty;
                    state_d    = l2_cache_pkg::st_refill;
                end
            end

            l2_cache_pkg::st_refill: begin
                pmem_read_o = 1'b1;
                if (pmem_resp_i) begin
                    ctrl.way_load[ctrl.victim_way] = 1'b1;
                    ctrl.data_sel   = l2_cache_pkg::datamux_pmem;
                    ctrl.valid_in   = 1'b1;
                    ctrl.dirty_load = 1'b1; // clean fill.
                    state_d = l2_cache_pkg::st_lookup;
                end
            end

            l2_cache_pkg::st_respond: begin
                mem_resp_o = 1'b1;
                state_d    = l2_cache_pkg::st_idle;
            end

            l2_cache_pkg::st_writeback: begin
                wb_sel_o     = 1'b1;
                pmem_write_o = 1'b1;
                if (pmem_resp_i) begin
                    ewb_yumi_o = 1'b1;
                    state_d    = l2_cache_pkg::st_idle;
                end
            end

            default: begin
                state_d = l2_cache_pkg::st_idle;
            end
        endcase
    end

endmodule

//--- hw/ewb.sv
module ewb (
    input  logic                                clk,
    input  logic                                arst_n_i,
    input  logic [l2_cache_pkg::line_width-1:0] data_i,
    input  logic [31:0]                         addr_i,
    input  logic                                load_i,
    input  logic [l2_cache_pkg::s_tag+l2_cache_pkg::s_index-1:0] tag_i,
    output logic                                hit_o,
    output logic [l2_cache_pkg::line_width-1:0] read_o,
    output logic                                empty_o,
    output logic [l2_cache_pkg::line_width-1:0] data_o,
    output logic [31:0]                         addr_o,
    input  logic                                yumi_i
);

    logic                                valid_q;
    logic [l2_cache_pkg::line_width-1:0] data_q;
    logic [31:0]                         addr_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (load_i) begin
            valid_q <= 1'b1;
        end else if (yumi_i) begin
            valid_q <= 1'b0; // memory took the line.
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            data_q <= data_i;
            addr_q <= addr_i;
        end
    end

    // line address compare, offset ignored.
    assign hit_o = valid_q && (addr_q[31:l2_cache_pkg::s_offset] == tag_i);

    assign read_o  = data_q; // upstream read path.
    assign data_o  = data_q; // write-back path.
    assign addr_o  = addr_q;
    assign empty_o = ~valid_q;

endmodule

//--- hw/l2_cache_datapath.sv
module l2_cache_datapath (
    input  logic                                clk,
    input  logic                                arst_n_i,
    input  logic [31:0]                         mem_address_i,
    input  logic [l2_cache_pkg::line_width-1:0] mem_wdata_i,
    input  logic [l2_cache_pkg::line_width-1:0] pmem_rdata_i,
    cache_ctrl_if.dp                            ctrl,
    output logic [l2_cache_pkg::line_width-1:0] rdata_o,
    output logic [31:0]                         pmem_address_o
);

    localparam int tag_lsb = l2_cache_pkg::s_offset + l2_cache_pkg::s_index;

    logic [l2_cache_pkg::s_index-1:0] index;
    logic [l2_cache_pkg::s_tag-1:0]   tag;

    // payload arrays.
    logic [l2_cache_pkg::s_tag-1:0]      tag_q  [l2_cache_pkg::num_ways][l2_cache_pkg::num_sets];
    logic [l2_cache_pkg::line_width-1:0] data_q [l2_cache_pkg::num_ways][l2_cache_pkg::num_sets];

    // control state arrays.
    logic [l2_cache_pkg::num_ways-1:0][l2_cache_pkg::num_sets-1:0] valid_q;
    logic [l2_cache_pkg::num_ways-1:0][l2_cache_pkg::num_sets-1:0] dirty_q;
    l2_cache_pkg::lru_t [l2_cache_pkg::num_sets-1:0]               lru_q;

    logic [l2_cache_pkg::num_ways-1:0]   way_hit;
    l2_cache_pkg::lru_t                  lru_cur;
    l2_cache_pkg::lru_t                  lru_next;
    l2_cache_pkg::way_t                  out_way;
    logic [l2_cache_pkg::line_width-1:0] data_in;

    assign index = mem_address_i[tag_lsb-1:l2_cache_pkg::s_offset];
    assign tag   = mem_address_i[31:tag_lsb];

    // parallel tag compare.
    always_comb begin
        for (int w = 0; w < l2_cache_pkg::num_ways; w++) begin
            way_hit[w] = valid_q[w][index] && (tag_q[w][index] == tag);
        end
    end

    always_comb begin
        ctrl.hit_way = '0;
        for (int w = 0; w < l2_cache_pkg::num_ways; w++) begin
            if (way_hit[w]) begin
                ctrl.hit_way = l2_cache_pkg::way_t'(w);
            end
        end
    end

    assign ctrl.hit = |way_hit;

    // follow the tree toward the lru leaf.
    assign lru_cur = lru_q[index];
    assign ctrl.victim_way = lru_cur[0] ? {1'b1, lru_cur[2]} : {1'b0, lru_cur[1]};
    assign ctrl.victim_dirty = valid_q[ctrl.victim_way][index]
                             & dirty_q[ctrl.victim_way][index];

    // point every bit on the path away from the accessed way.
    always_comb begin
        lru_next    = lru_cur;
        lru_next[0] = ~ctrl.hit_way[1];
        if (ctrl.hit_way[1]) begin
            lru_next[2] = ~ctrl.hit_way[0];
        end else begin
            lru_next[1] = ~ctrl.hit_way[0];
        end
    end

    assign data_in = (ctrl.data_sel == l2_cache_pkg::datamux_pmem) ? pmem_rdata_i : mem_wdata_i;

    // hit line when present, victim line on a miss.
    assign out_way = ctrl.hit ? ctrl.hit_way : ctrl.victim_way;
    assign rdata_o = data_q[out_way][index];

    always_comb begin
        if (ctrl.addr_sel == l2_cache_pkg::pmemaddr_victim) begin
            pmem_address_o = {tag_q[ctrl.victim_way][index], index,
                              {l2_cache_pkg::s_offset{1'b0}}};
        end else begin
            pmem_address_o = {mem_address_i[31:l2_cache_pkg::s_offset],
                              {l2_cache_pkg::s_offset{1'b0}}};
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            for (int w = 0; w < l2_cache_pkg::num_ways; w++) begin
                if (ctrl.way_load[w]) begin
                    valid_q[w][index] <= ctrl.valid_in;
                    if (ctrl.dirty_load) begin
                        dirty_q[w][index] <= ctrl.dirty_in;
                    end
                end
            end
            if (ctrl.lru_load) begin
                lru_q[index] <= lru_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < l2_cache_pkg::num_ways; w++) begin
            if (ctrl.way_load[w]) begin
                tag_q[w][index]  <= tag;
                data_q[w][index] <= data_in;
            end
        end
    end

endmodule

//--- hw/cache_ctrl_if.sv
interface cache_ctrl_if;

    // control to datapath.
    logic [l2_cache_pkg::num_ways-1:0] way_load;
    logic                              valid_in;
    logic                              dirty_in;
    logic                              dirty_load;
    logic                              lru_load;
    l2_cache_pkg::datamux_sel_t        data_sel;
    l2_cache_pkg::pmemaddr_sel_t       addr_sel;

    // datapath to control.
    logic                              hit;
    l2_cache_pkg::way_t                hit_way;
    l2_cache_pkg::way_t                victim_way;
    logic                              victim_dirty;

    modport ctrl (
        output way_load, valid_in, dirty_in, dirty_load, lru_load, data_sel, addr_sel,
        input  hit, hit_way, victim_way, victim_dirty
    );

    modport dp (
        input  way_load, valid_in, dirty_in, dirty_load, lru_load, data_sel, addr_sel,
        output hit, hit_way, victim_way, victim_dirty
    );

endinterface

//--- hw/l2_cache_pkg.sv
package l2_cache_pkg;

    // line geometry.
    localparam int s_offset   = 5;
    localparam int s_index    = 3;
    localparam int s_tag      = 32 - s_offset - s_index;
    localparam int num_ways   = 4;
    localparam int num_sets   = 2 ** s_index;
    localparam int line_width = 8 * (2 ** s_offset);

    // tree plru, one per set.
    // bit 0 picks the pair, bit 1 picks within ways 0-1, bit 2 within ways 2-3.
    // every bit points at the less recently used side.
    typedef logic [2:0] lru_t;

    typedef logic [1:0] way_t;

    // source of a data array write.
    typedef enum logic {
        datamux_wdata,
        datamux_pmem
    } datamux_sel_t;

    // memory address source.
    typedef enum logic {
        pmemaddr_req,
        pmemaddr_victim
    } pmemaddr_sel_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_evict,
        st_refill,
        st_respond,
        st_writeback
    } cache_state_t;

endpackage
